// File: hw/vmul_params.svh
// Sizes are fixed for a single-lane register file with 64-bit words and 8 words per register
`ifndef VMUL_PARAMS_SVH
`define VMUL_PARAMS_SVH

// Datapath word width in bits
`define VMUL_ELEN 64

// In-flight instructions held by the unit
`define VMUL_INSN_QUEUE_DEPTH 4

// Results waiting for a register-file grant
`define VMUL_RESULT_QUEUE_DEPTH 2

// Instruction ids, also the width of the done vector
`define VMUL_NR_VINSN 8

// Vector length counter width, up to 64 elements
`define VMUL_VL_WIDTH 7

// Register file geometry
`define VMUL_VREG_WORDS 8
`define VMUL_ADDR_WIDTH 8

// Pipeline registers of each SIMD multiplier
`define VMUL_LAT_EW64 3
`define VMUL_LAT_EW32 2
`define VMUL_LAT_EW16 1
`define VMUL_LAT_EW8  1

`endif

// File: hw/vmul_pkg.sv
// Shared types of the vector multiplier; word_be assumes a word of 8 bytes
`include "vmul_params.svh"

package vmul_pkg;

  typedef logic [`VMUL_ELEN-1:0]   elen_t;
  typedef logic [`VMUL_ELEN/8-1:0] strb_t;

  // Encoding matches log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef enum logic [2:0] {
    VMUL,
    VMULH,
    VMULHU,
    VMACC,
    VNMSAC
  } vmul_op_e;

  typedef logic [$clog2(`VMUL_NR_VINSN)-1:0] vid_t;
  typedef logic [`VMUL_VL_WIDTH-1:0]         vl_t;
  typedef logic [`VMUL_ADDR_WIDTH-1:0]       vaddr_t;

  typedef struct packed {
    vmul_op_e    op;
    vsew_e       vsew;
    vl_t         vl;
    logic [4:0]  vd;
    vid_t        id;
    logic        use_scalar_op;
    elen_t       scalar_op;
    logic        use_vs1;
    logic        use_vd_op;
  } vmul_insn_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } vrf_wr_t;

  function automatic vl_t elems_per_word(vsew_e vsew);
    return vl_t'((`VMUL_ELEN / 8) >> vsew);
  endfunction

  // Byte enables of the elements still inside vl on the current word
  function automatic strb_t word_be(vl_t remaining, vsew_e vsew);
    vl_t   nbytes;
    strb_t be;
    nbytes = (remaining < elems_per_word(vsew)) ? remaining : elems_per_word(vsew);
    nbytes = nbytes << vsew;
    for (int b = 0; b < $bits(strb_t); b++) begin
      be[b] = (b < nbytes);
    end
    return be;
  endfunction

endpackage

// File: hw/vmul_insn_queue.sv
// Every accepted instruction needs a nonzero vl, or its phases never complete
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_insn_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_pkg::vmul_insn_t      insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  output vmul_pkg::vmul_insn_t      issue_insn_o,
  output logic                      issue_valid_o,
  output vmul_pkg::vl_t             issue_remaining_o,
  input  logic                      issue_fire_i,
  output vmul_pkg::vmul_insn_t      processing_insn_o,
  output vmul_pkg::vl_t             processing_remaining_o,
  input  logic                      process_fire_i,
  output vmul_pkg::vmul_insn_t      commit_insn_o,
  input  logic                      commit_fire_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned Depth = `VMUL_INSN_QUEUE_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;

  function automatic pnt_t next_pnt(pnt_t pnt);
    return (pnt == pnt_t'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  vmul_pkg::vmul_insn_t mem_q [Depth];
  pnt_t                 accept_pnt_q;
  logic                 accept;

  // Index 0 is issue, 1 is processing, 2 is commit
  logic                       [2:0] fire;
  logic                       [2:0] last;
  cnt_t                       [2:0] cnt;
  vmul_pkg::vl_t              [2:0] rem;
  vmul_pkg::vmul_insn_t       [2:0] cur;

  assign fire         = {commit_fire_i, process_fire_i, issue_fire_i};
  // An instruction leaves the store only after its commit phase
  assign insn_ready_o = (cnt[2] != cnt_t'(Depth));
  assign accept       = insn_valid_i & insn_ready_o;

  // Instruction store, written at the accept pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q        <= '{default: '0};
      accept_pnt_q <= '0;
    end else if (accept) begin
      mem_q[accept_pnt_q] <= insn_i;
      accept_pnt_q        <= next_pnt(accept_pnt_q);
    end
  end

  for (genvar p = 0; p < 3; p++) begin : gen_phase
    pnt_t          pnt_q;
    pnt_t          pnt_nxt;
    cnt_t          cnt_q;
    vmul_pkg::vl_t rem_q;
    vmul_pkg::vl_t step;

    assign cur[p]  = mem_q[pnt_q];
    assign step    = vmul_pkg::elems_per_word(cur[p].vsew);
    assign pnt_nxt = next_pnt(pnt_q);
    // The final word may hold fewer elements than a full step
    assign last[p] = fire[p] && (rem_q <= step);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        pnt_q <= '0;
        cnt_q <= '0;
        rem_q <= '0;
      end else begin
        cnt_q <= cnt_q + cnt_t'(accept) - cnt_t'(last[p]);
        if (last[p]) begin
          pnt_q <= pnt_nxt;
          // Next entry may be the one being written in this cycle
          rem_q <= (pnt_nxt == accept_pnt_q) ? insn_i.vl : mem_q[pnt_nxt].vl;
        end else if (fire[p]) begin
          rem_q <= rem_q - step;
        end else if (accept && cnt_q == '0) begin
          rem_q <= insn_i.vl;
        end
      end
    end

    assign cnt[p] = cnt_q;
    assign rem[p] = rem_q;

    // Strobes from the datapath only ever act on a held instruction
    a_fire_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fire[p] |-> cnt_q != '0);
  end

  assign issue_insn_o           = cur[0];
  assign issue_valid_o          = (cnt[0] != '0);
  assign issue_remaining_o      = rem[0];
  assign processing_insn_o      = cur[1];
  assign processing_remaining_o = rem[1];
  assign commit_insn_o          = cur[2];

  always_comb begin
    vinsn_done_o = '0;
    if (last[2]) begin
      vinsn_done_o[cur[2].id] = 1'b1;
    end
  end

  // Phases finish in order, so a later phase never holds fewer instructions
  a_phase_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt[0] <= cnt[1] && cnt[1] <= cnt[2] && cnt[2] <= cnt_t'(Depth));

endmodule

// File: hw/vmul_simd_mul.sv
// Results are truncated to the element width; NumPipeRegs must be at least 1
`timescale 1ns/1ps

module vmul_simd_mul #(
  parameter vmul_pkg::vsew_e Vsew        = vmul_pkg::EW64,
  parameter int unsigned     NumPipeRegs = 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_pkg::elen_t    operand_a_i,
  input  vmul_pkg::elen_t    operand_b_i,
  input  vmul_pkg::elen_t    operand_c_i,
  input  vmul_pkg::vmul_op_e op_i,
  input  logic               valid_i,
  output logic               ready_o,
  output vmul_pkg::elen_t    result_o,
  output logic               valid_o,
  input  logic               ready_i
);

  localparam int unsigned Sew    = 8 << Vsew;
  localparam int unsigned NrElem = $bits(vmul_pkg::elen_t) / Sew;

  vmul_pkg::elen_t result_d;

  // a is vs1 or the scalar, b is vs2, c is the old vd value
  for (genvar e = 0; e < NrElem; e++) begin : gen_elem
    logic [Sew-1:0]   a;
    logic [Sew-1:0]   b;
    logic [Sew-1:0]   c;
    logic [Sew-1:0]   r;
    logic [2*Sew-1:0] prod_s;
    logic [2*Sew-1:0] prod_u;

    assign a      = operand_a_i[e*Sew +: Sew];
    assign b      = operand_b_i[e*Sew +: Sew];
    assign c      = operand_c_i[e*Sew +: Sew];
    assign prod_s = $signed(a) * $signed(b);
    assign prod_u = a * b;

    always_comb begin
      case (op_i)
        vmul_pkg::VMULH:  r = prod_s[2*Sew-1:Sew];
        vmul_pkg::VMULHU: r = prod_u[2*Sew-1:Sew];
        vmul_pkg::VMACC:  r = c + prod_u[Sew-1:0];
        vmul_pkg::VNMSAC: r = c - prod_u[Sew-1:0];
        default:          r = prod_u[Sew-1:0];
      endcase
    end

    assign result_d[e*Sew +: Sew] = r;
  end

  logic            [NumPipeRegs-1:0] valid_q;
  vmul_pkg::elen_t [NumPipeRegs-1:0] data_q;
  logic            [NumPipeRegs:0]   stage_ready;

  assign stage_ready[NumPipeRegs] = ready_i;

  for (genvar s = 0; s < NumPipeRegs; s++) begin : gen_stage
    logic            in_valid;
    vmul_pkg::elen_t in_data;
    logic            v_q;
    vmul_pkg::elen_t d_q;

    if (s == 0) begin : gen_head
      assign in_valid = valid_i;
      assign in_data  = result_d;
    end else begin : gen_body
      assign in_valid = valid_q[s-1];
      assign in_data  = data_q[s-1];
    end

    // A stage takes new data when empty or when its word moves on
    assign stage_ready[s] = ~v_q | stage_ready[s+1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        v_q <= 1'b0;
      end else if (stage_ready[s]) begin
        v_q <= in_valid;
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[s] && in_valid) begin
        d_q <= in_data;
      end
    end

    assign valid_q[s] = v_q;
    assign data_q[s]  = d_q;
  end

  assign ready_o  = stage_ready[0];
  assign valid_o  = valid_q[NumPipeRegs-1];
  assign result_o = data_q[NumPipeRegs-1];

  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o));

endmodule

// File: hw/vmul_result_queue.sv
// Write requests wait here for a grant; push only while full_o is low
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_result_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  vmul_pkg::vrf_wr_t wr_i,
  output logic              full_o,
  output logic              result_req_o,
  output vmul_pkg::vrf_wr_t result_o,
  input  logic              result_gnt_i
);

  localparam int unsigned Depth = `VMUL_RESULT_QUEUE_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;

  vmul_pkg::vrf_wr_t mem_q [Depth];
  pnt_t              wr_pnt_q;
  pnt_t              rd_pnt_q;
  cnt_t              cnt_q;
  logic              pop;

  assign full_o       = (cnt_q == cnt_t'(Depth));
  assign result_req_o = (cnt_q != '0);
  assign result_o     = mem_q[rd_pnt_q];
  assign pop          = result_gnt_i & result_req_o;

  always_ff @(posedge clk_i) begin
    if (push_i && !full_o) begin
      mem_q[wr_pnt_q] <= wr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i && !full_o) begin
        wr_pnt_q <= (wr_pnt_q == pnt_t'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == pnt_t'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_t'(push_i && !full_o) - cnt_t'(pop);
    end
  end

  // Multiplier back-pressure must keep pushes away from a full FIFO
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // The register file only grants a pending request
  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o);

endmodule

// File: hw/vmul_unit.sv
// Single-lane register file; vl must be nonzero and fit in one vector register
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vmul_pkg::vmul_insn_t      insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  input  vmul_pkg::elen_t [2:0]     operand_i,
  input  logic            [2:0]     operand_valid_i,
  output logic            [2:0]     operand_ready_o,
  output logic                      result_req_o,
  output vmul_pkg::vrf_wr_t         result_o,
  input  logic                      result_gnt_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  // Indexed by element width encoding
  localparam int unsigned Lat [4] = '{`VMUL_LAT_EW8, `VMUL_LAT_EW16,
                                      `VMUL_LAT_EW32, `VMUL_LAT_EW64};

  vmul_pkg::vmul_insn_t issue_insn;
  vmul_pkg::vmul_insn_t processing_insn;
  vmul_pkg::vmul_insn_t commit_insn;
  vmul_pkg::vl_t        issue_remaining;
  vmul_pkg::vl_t        processing_remaining;
  logic                 issue_valid;
  logic                 issue_fire;
  logic                 process_fire;
  logic                 commit_fire;
  logic                 result_full;

  vmul_insn_queue i_insn_queue (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .insn_i                 (insn_i),
    .insn_valid_i           (insn_valid_i),
    .insn_ready_o           (insn_ready_o),
    .issue_insn_o           (issue_insn),
    .issue_valid_o          (issue_valid),
    .issue_remaining_o      (issue_remaining),
    .issue_fire_i           (issue_fire),
    .processing_insn_o      (processing_insn),
    .processing_remaining_o (processing_remaining),
    .process_fire_i         (process_fire),
    .commit_insn_o          (commit_insn),
    .commit_fire_i          (commit_fire),
    .vinsn_done_o           (vinsn_done_o)
  );

  vmul_pkg::elen_t scalar_op;

  always_comb begin
    case (issue_insn.vsew)
      vmul_pkg::EW8:  scalar_op = {8{issue_insn.scalar_op[7:0]}};
      vmul_pkg::EW16: scalar_op = {4{issue_insn.scalar_op[15:0]}};
      vmul_pkg::EW32: scalar_op = {2{issue_insn.scalar_op[31:0]}};
      default:        scalar_op = issue_insn.scalar_op;
    endcase
  end

  // Operand queues used by the issuing instruction, vd vs2 vs1
  logic [2:0] use_op;
  logic       operands_valid;

  assign use_op = {issue_insn.use_vd_op, 1'b1,
                   issue_insn.use_vs1 & ~issue_insn.use_scalar_op};
  assign operands_valid = &(operand_valid_i | ~use_op);

  // Tail elements past vl enter the multiplier as zero
  vmul_pkg::strb_t issue_be;
  vmul_pkg::elen_t tail_mask;
  vmul_pkg::elen_t mul_a;
  vmul_pkg::elen_t mul_b;

  assign issue_be = vmul_pkg::word_be(issue_remaining, issue_insn.vsew);
  for (genvar b = 0; b < $bits(vmul_pkg::strb_t); b++) begin : gen_tail_mask
    assign tail_mask[8*b +: 8] = {8{issue_be[b]}};
  end
  assign mul_a = (issue_insn.use_scalar_op ? scalar_op : operand_i[0]) & tail_mask;
  assign mul_b = operand_i[1] & tail_mask;

  logic            [3:0] mul_in_valid;
  logic            [3:0] mul_in_ready;
  logic            [3:0] mul_out_valid;
  logic            [3:0] mul_out_ready;
  vmul_pkg::elen_t [3:0] mul_result;

  for (genvar w = 0; w < 4; w++) begin : gen_mul
    vmul_simd_mul #(
      .Vsew        (vmul_pkg::vsew_e'(w)),
      .NumPipeRegs (Lat[w])
    ) i_simd_mul (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .operand_a_i (mul_a),
      .operand_b_i (mul_b),
      .operand_c_i (operand_i[2]),
      .op_i        (issue_insn.op),
      .valid_i     (mul_in_valid[w]),
      .ready_o     (mul_in_ready[w]),
      .result_o    (mul_result[w]),
      .valid_o     (mul_out_valid[w]),
      .ready_i     (mul_out_ready[w])
    );
  end

  // Issue feeds one multiplier, results are drained from the oldest one
  always_comb begin
    mul_in_valid                        = '0;
    mul_in_valid[issue_insn.vsew]       = issue_valid & operands_valid;
    mul_out_ready                       = '0;
    mul_out_ready[processing_insn.vsew] = ~result_full;
  end

  assign issue_fire      = issue_valid & operands_valid & mul_in_ready[issue_insn.vsew];
  assign operand_ready_o = issue_fire ? use_op : 3'b000;
  assign process_fire    = mul_out_valid[processing_insn.vsew] & ~result_full;

  vmul_pkg::vl_t     word_idx;
  vmul_pkg::vrf_wr_t wr;

  assign word_idx = (processing_insn.vl - processing_remaining) >>
                    (2'd3 - processing_insn.vsew);

  always_comb begin
    wr.id    = processing_insn.id;
    wr.addr  = vmul_pkg::vaddr_t'(processing_insn.vd * `VMUL_VREG_WORDS) +
               vmul_pkg::vaddr_t'(word_idx);
    wr.wdata = mul_result[processing_insn.vsew];
    wr.be    = vmul_pkg::word_be(processing_remaining, processing_insn.vsew);
  end

  vmul_result_queue i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (process_fire),
    .wr_i         (wr),
    .full_o       (result_full),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i)
  );

  assign commit_fire = result_gnt_i & result_req_o;

  // Words leave the FIFO in the order their instructions commit
  a_commit_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_o.id == commit_insn.id);

endmodule

// File: verification/tb_vmul_unit.sv
// Checks vmul_unit against a reference model; wdata is compared only on enabled bytes
`timescale 1ns/1ps
`include "vmul_params.svh"

module tb_vmul_unit;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  vmul_pkg::vmul_insn_t      insn_i;
  logic                      insn_valid_i;
  logic                      insn_ready_o;
  vmul_pkg::elen_t [2:0]     operand_i;
  logic            [2:0]     operand_valid_i;
  logic            [2:0]     operand_ready_o;
  logic                      result_req_o;
  vmul_pkg::vrf_wr_t         result_o;
  logic                      result_gnt_i;
  logic                      gnt_en;
  logic [`VMUL_NR_VINSN-1:0] vinsn_done_o;

  // Stimulus and expected results, built before reset is released
  vmul_pkg::vmul_insn_t insns [$];
  vmul_pkg::elen_t      opq [3][$];
  vmul_pkg::vrf_wr_t    exp_wr [$];
  logic                 exp_last [$];
  logic [2:0]           word_use [$];

  int   total_words = 0;
  int   cycle_limit = 0;
  int   cycle_cnt = 0;
  int   n_granted = 0;
  int   n_issued = 0;
  int   n_acc = 0;
  int   n_done = 0;
  int   insn_idx = 0;
  int   op_head [3] = '{0, 0, 0};
  logic insn_taken = 1'b0;
  logic [2:0] op_taken = 3'b000;

  always #10 clk_i = ~clk_i;

  // Register file grants only a pending request
  assign result_gnt_i = gnt_en & result_req_o;

  vmul_unit vmul_unit_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_o        (result_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_o    (vinsn_done_o)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run("First mismatch, stopping");
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] elem_mask(int sew);
    return (sew == 64) ? '1 : (64'd1 << sew) - 64'd1;
  endfunction

  function automatic logic [63:0] replicate(logic [63:0] s, int sew);
    logic [63:0] r;
    r = '0;
    for (int e = 0; e < 64 / sew; e++) begin
      r = r | ((s & elem_mask(sew)) << (e * sew));
    end
    return r;
  endfunction

  function automatic logic [63:0] byte_mask(vmul_pkg::strb_t be);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  function automatic vmul_pkg::strb_t ref_be(int remaining, int sew);
    int n;
    n = (remaining < 64 / sew) ? remaining : 64 / sew;
    return vmul_pkg::strb_t'((16'd1 << (n * sew / 8)) - 16'd1);
  endfunction

  // Expected word: a is vs1 or scalar, b is vs2, c is the old vd
  function automatic logic [63:0] ref_word(vmul_pkg::vmul_op_e op, int sew, logic [63:0] a,
                                           logic [63:0] b, logic [63:0] c);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] prod;
    logic [63:0]  m;
    logic [63:0]  ec;
    logic [63:0]  r;
    logic [63:0]  res;
    m   = elem_mask(sew);
    res = '0;
    for (int e = 0; e < 64 / sew; e++) begin
      ea = 128'((a >> (e * sew)) & m);
      eb = 128'((b >> (e * sew)) & m);
      ec = (c >> (e * sew)) & m;
      // Signed high half needs both factors sign extended to the full product width
      if (op == vmul_pkg::VMULH && ea[sew-1]) begin
        ea = ea | ~{64'd0, m};
      end
      if (op == vmul_pkg::VMULH && eb[sew-1]) begin
        eb = eb | ~{64'd0, m};
      end
      prod = ea * eb;
      case (op)
        vmul_pkg::VMULH, vmul_pkg::VMULHU: r = 64'(prod >> sew);
        vmul_pkg::VMACC:                   r = ec + prod[63:0];
        vmul_pkg::VNMSAC:                  r = ec - prod[63:0];
        default:                           r = prod[63:0];
      endcase
      res = res | ((r & m) << (e * sew));
    end
    return res;
  endfunction

  task automatic add_insn(input vmul_pkg::vmul_op_e op, input vmul_pkg::vsew_e vsew,
                          input int vl, input logic use_scalar);
    vmul_pkg::vmul_insn_t insn;
    vmul_pkg::vrf_wr_t    wr;
    logic                 accum;
    logic [63:0]          a;
    logic [63:0]          b;
    logic [63:0]          c;
    int                   sew;
    int                   epw;
    int                   nw;
    sew   = 8 << vsew;
    epw   = 64 / sew;
    nw    = (vl + epw - 1) / epw;
    accum = (op == vmul_pkg::VMACC) || (op == vmul_pkg::VNMSAC);
    insn  = '0;
    insn.op            = op;
    insn.vsew          = vsew;
    insn.vl            = vmul_pkg::vl_t'(vl);
    insn.vd            = 5'($urandom % 32);
    insn.id            = vmul_pkg::vid_t'(insns.size());
    insn.use_scalar_op = use_scalar;
    insn.scalar_op     = rand64();
    insn.use_vs1       = 1'b1;
    insn.use_vd_op     = accum;
    for (int k = 0; k < nw; k++) begin
      b = rand64();
      opq[1].push_back(b);
      a = replicate(insn.scalar_op, sew);
      if (!use_scalar) begin
        a = rand64();
        opq[0].push_back(a);
      end
      c = '0;
      if (accum) begin
        c = rand64();
        opq[2].push_back(c);
      end
      wr.id    = insn.id;
      wr.addr  = vmul_pkg::vaddr_t'(insn.vd * `VMUL_VREG_WORDS + k);
      wr.be    = ref_be(vl - k * epw, sew);
      wr.wdata = ref_word(op, sew, a, b, c);
      exp_wr.push_back(wr);
      exp_last.push_back(k == nw - 1);
      word_use.push_back({accum, 1'b1, ~use_scalar});
    end
    insns.push_back(insn);
    total_words += nw;
  endtask

  // Driver: advances lists on last cycle's handshakes, then drives the next values
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (insn_taken) begin
        insn_idx++;
      end
      insn_valid_i <= (insn_idx < insns.size());
      if (insn_idx < insns.size()) begin
        insn_i <= insns[insn_idx];
      end
      for (int q = 0; q < 3; q++) begin
        if (op_taken[q]) begin
          op_head[q]++;
        end
        operand_valid_i[q] <= (op_head[q] < opq[q].size()) && ($urandom % 4 != 0);
        operand_i[q]       <= (op_head[q] < opq[q].size()) ? opq[q][op_head[q]] : '0;
      end
      // Long stretches without grants fill the result FIFO and the pipelines
      gnt_en <= (cycle_cnt % 300 >= 100) && ($urandom % 4 != 0);
    end
  end

  // Compare process, sampling in the middle of the cycle
  always @(negedge clk_i) begin
    vmul_pkg::vrf_wr_t         exp;
    logic [`VMUL_NR_VINSN-1:0] done_exp;
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      stop_run("Timeout: not all results were written before the cycle limit");
    end else if (!rst_ni) begin
      check_value("insn_ready_o", insn_ready_o, 1);
      check_value("result_req_o", result_req_o, 0);
      check_value("operand_ready_o", operand_ready_o, 0);
      check_value("vinsn_done_o", vinsn_done_o, 0);
    end else begin
      check_value("insn_ready_o", insn_ready_o, (n_acc - n_done) != 4);
      if (operand_ready_o != 3'b000) begin
        if (n_issued >= word_use.size()) begin
          stop_run("Operand ready raised after every word was issued");
        end
        check_value("operand_ready_o", operand_ready_o, word_use[n_issued]);
        check_value("operand_valid_i", operand_valid_i & operand_ready_o, operand_ready_o);
      end
      done_exp = '0;
      if (result_req_o && result_gnt_i) begin
        if (n_granted >= exp_wr.size()) begin
          stop_run("Write request granted after every expected result");
        end
        exp = exp_wr[n_granted];
        done_exp[exp.id] = exp_last[n_granted];
        check_value("result_o.id", result_o.id, exp.id);
        check_value("result_o.addr", result_o.addr, exp.addr);
        check_value("result_o.be", result_o.be, exp.be);
        check_value("result_o.wdata", result_o.wdata & byte_mask(exp.be),
                    exp.wdata & byte_mask(exp.be));
        n_granted++;
      end
      check_value("vinsn_done_o", vinsn_done_o, done_exp);
      insn_taken = insn_valid_i & insn_ready_o;
      op_taken   = operand_valid_i & operand_ready_o;
      n_acc      += insn_taken;
      n_issued   += op_taken[1];
      n_done     += (vinsn_done_o != '0);
    end
  end

  initial begin
    int w;
    void'($urandom(32'h05e2_21c3));
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = 3'b000;
    gnt_en          = 1'b0;
    // Every operation at every width, then scalar and partial last words
    for (w = 0; w < 4; w++) begin
      for (int o = 0; o < 5; o++) begin
        add_insn(vmul_pkg::vmul_op_e'(o), vmul_pkg::vsew_e'(w), 2 * (8 >> w), 1'b0);
      end
      add_insn(vmul_pkg::VMUL, vmul_pkg::vsew_e'(w), 2 * (8 >> w), 1'b1);
      add_insn(vmul_pkg::VMACC, vmul_pkg::vsew_e'(w), 3 * (8 >> w), 1'b1);
      if (w < 3) begin
        add_insn(vmul_pkg::VMULH, vmul_pkg::vsew_e'(w), 2 * (8 >> w) - 1, 1'b0);
        add_insn(vmul_pkg::VNMSAC, vmul_pkg::vsew_e'(w), (8 >> w) + 1, 1'b0);
      end
    end
    for (int i = 0; i < 24; i++) begin
      w = $urandom % 4;
      add_insn(vmul_pkg::vmul_op_e'($urandom % 5), vmul_pkg::vsew_e'(w),
               1 + $urandom % (8 * (8 >> w)), ($urandom % 3) == 0);
    end
    cycle_limit = 20 * total_words + 200;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait (n_granted == total_words);
    // Catch stray requests after the last word
    repeat (20) @(negedge clk_i);
    check_value("result_req_o", result_req_o, 0);
    $display("No errors");
    $finish;
  end

endmodule

// File: files.f
+incdir+hw
hw/vmul_pkg.sv
hw/vmul_insn_queue.sv
hw/vmul_simd_mul.sv
hw/vmul_result_queue.sv
hw/vmul_unit.sv
verification/tb_vmul_unit.sv

// File: Bender.yml
package:
  name: vmul_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/vmul_pkg.sv
      - hw/vmul_insn_queue.sv
      - hw/vmul_simd_mul.sv
      - hw/vmul_result_queue.sv
      - hw/vmul_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_vmul_unit.sv
